// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cart_cfg_tb
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS RUNFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/cart_cfg_checker.sv ====
module cart_cfg_checker #(
    parameter int ram_aw = cart_pkg::CPU_RAM_AW_DEFAULT
) (
    input logic              sys,
    input logic              rst_n,
    input logic              host_request,
    input logic              host_write,
    input logic [15:0]       host_address,
    input logic [15:0]       host_wdata,
    input logic [15:0]       host_rdata,
    input logic              host_ack,
    input logic              soft_reset,
    input logic              cpu_ready,
    input logic              cmd_valid,
    input logic [7:0]        cmd,
    input logic [31:0]       cmd_arg0,
    input logic [31:0]       cmd_arg1,
    input logic              cmd_ready,
    input logic              done,
    input logic              done_error,
    input logic [1:0]        data_write,
    input logic [31:0]       result_data,
    input logic [ram_aw-1:0] ram_address,
    input logic              ram_write,
    input logic [15:0]       ram_wdata,
    input logic [15:0]       ram_rdata,
    input logic [15:0]       isv_rd_ptr
);

    import cart_pkg::*;
    import cfg_regs_pkg::*;

    string             test_name = "";
    int                fail_count = 0;
    logic [1:0]        region;
    logic [ram_aw-1:0] host_idx;
    logic [31:0]       d0_sh;
    logic [31:0]       d1_sh;
    logic [31:0]       id_sh;
    logic [31:0]       arg0_sh;
    logic [31:0]       arg1_sh;
    logic [15:0]       ptr_sh;
    logic [15:0]       exp_rdata;
    logic [15:0]       cpu_exp_q;
    logic [7:0]        cmd_sh;
    logic [7:0]        pay_cmd_sh;
    logic              busy_sh;
    logic              err_sh;
    logic              cmd_wr_q;
    logic              exp_known;
    logic              cpu_rd_q;
    logic [15:0]       ram_sh [2**ram_aw];    // Host byte order.
    logic              ram_known [2**ram_aw];

    assign region   = host_address[15:14];
    assign host_idx = host_address[ram_aw:1];

    function automatic logic [15:0] swap_bytes(input logic [15:0] v);
        return {v[7:0], v[15:8]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shadow state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys) begin
        if (host_request && host_write && region == REGION_RAM) begin
            ram_sh[host_idx] <= host_wdata;
        end
        if (ram_write) begin
            ram_sh[ram_address] <= swap_bytes(ram_wdata);
        end
        cpu_exp_q <= swap_bytes(ram_sh[ram_address]);    // Old word on a write.
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**ram_aw; i++) begin
                ram_known[i] <= 1'b0;
            end
            cpu_rd_q <= 1'b0;
        end else begin
            if (host_request && host_write && region == REGION_RAM) begin
                ram_known[host_idx] <= 1'b1;
            end
            if (ram_write) begin
                ram_known[ram_address] <= 1'b1;
            end
            cpu_rd_q <= ram_known[ram_address];
        end
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            d0_sh      <= '0;
            d1_sh      <= '0;
            id_sh      <= '0;
            arg0_sh    <= '0;
            arg1_sh    <= '0;
            ptr_sh     <= '0;
            cmd_sh     <= '0;
            pay_cmd_sh <= '0;
            busy_sh    <= 1'b0;
            err_sh     <= 1'b0;
            cmd_wr_q   <= 1'b0;
        end else begin
            cmd_wr_q <= 1'b0;
            if (host_request && host_write && region == REGION_CFG) begin
                case (cfg_reg_e'(host_address[3:1]))
                    REG_COMMAND: begin
                        cmd_sh   <= host_wdata[7:0];
                        cmd_wr_q <= 1'b1;
                    end
                    REG_DATA0_H: d0_sh[31:16] <= host_wdata;
                    REG_DATA0_L: d0_sh[15:0]  <= host_wdata;
                    REG_DATA1_H: d1_sh[31:16] <= host_wdata;
                    REG_DATA1_L: d1_sh[15:0]  <= host_wdata;
                    default: ;
                endcase
            end
            if (host_request && host_write && region == REGION_ISV) begin
                case (host_address[4:1])
                    4'h0: id_sh[31:16] <= host_wdata;
                    4'h1: id_sh[15:0]  <= host_wdata;
                    4'hb: ptr_sh       <= host_wdata;
                    default: ;
                endcase
            end
            if (done) begin
                busy_sh <= 1'b0;
                err_sh  <= done_error;
                if (data_write[0]) d0_sh <= result_data;    // Beats a host write.
                if (data_write[1]) d1_sh <= result_data;
            end
            if (cmd_wr_q) begin
                if (!busy_sh) begin
                    busy_sh    <= 1'b1;
                    pay_cmd_sh <= cmd_sh;
                    arg0_sh    <= d0_sh;
                    arg1_sh    <= d1_sh;
                end else begin
                    err_sh <= 1'b1;    // Overlap.
                end
            end
            if (soft_reset) ptr_sh <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected host read data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        exp_known = 1'b1;
        exp_rdata = 16'd0;
        case (region)
            REGION_CFG: begin
                case (cfg_reg_e'(host_address[3:1]))
                    REG_STATUS:    exp_rdata = {cpu_ready, busy_sh, 1'b0, err_sh, 12'd0};
                    REG_COMMAND:   exp_rdata = {8'd0, cmd_sh};
                    REG_DATA0_H:   exp_rdata = d0_sh[31:16];
                    REG_DATA0_L:   exp_rdata = d0_sh[15:0];
                    REG_DATA1_H:   exp_rdata = d1_sh[31:16];
                    REG_DATA1_L:   exp_rdata = d1_sh[15:0];
                    REG_VERSION_H: exp_rdata = cart_version[31:16];
                    REG_VERSION_L: exp_rdata = cart_version[15:0];
                endcase
            end
            REGION_RAM: begin
                exp_known = ram_known[host_idx];
                exp_rdata = ram_sh[host_idx];
            end
            REGION_ISV: begin
                if (host_address[4:1] == 4'h0) exp_rdata = id_sh[31:16];
                if (host_address[4:1] == 4'h1) exp_rdata = id_sh[15:0];
                if (host_address[4:1] == 4'hb) exp_rdata = ptr_sh;
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_ack_follows: assert property (@(posedge sys) disable iff (!rst_n)
        host_request |=> host_ack)
        else begin
            fail_count++;
            $error("ERROR %s: host_ack expected 1 actual 0", test_name);
        end

    a_ack_cause: assert property (@(posedge sys) disable iff (!rst_n)
        host_ack |-> $past(host_request))
        else begin
            fail_count++;
            $error("ERROR %s: host_request before ack expected 1 actual 0", test_name);
        end

    a_rdata_idle: assert property (@(posedge sys) disable iff (!rst_n)
        !host_ack |-> host_rdata == 16'd0)
        else begin
            fail_count++;
            $error("ERROR %s: idle host_rdata expected 0000 actual %h",
                   test_name, $sampled(host_rdata));
        end

    a_rdata: assert property (@(posedge sys) disable iff (!rst_n)
        host_ack && !host_write && exp_known |-> host_rdata == exp_rdata)
        else begin
            fail_count++;
            $error("ERROR %s: read of %h expected %h actual %h", test_name,
                   $sampled(host_address), $sampled(exp_rdata), $sampled(host_rdata));
        end

    a_cmd_hold: assert property (@(posedge sys) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd) && $stable(cmd_arg0)
            && $stable(cmd_arg1))
        else begin
            fail_count++;
            $error("ERROR %s: held cmd expected %h actual %h", test_name,
                   pay_cmd_sh, $sampled(cmd));
        end

    a_cmd_payload: assert property (@(posedge sys) disable iff (!rst_n)
        $rose(cmd_valid) |-> {cmd, cmd_arg0, cmd_arg1} == {pay_cmd_sh, arg0_sh, arg1_sh})
        else begin
            fail_count++;
            $error("ERROR %s: payload expected %h %h %h actual %h %h %h", test_name,
                   pay_cmd_sh, arg0_sh, arg1_sh,
                   $sampled(cmd), $sampled(cmd_arg0), $sampled(cmd_arg1));
        end

    a_cpu_ram: assert property (@(posedge sys) disable iff (!rst_n)
        cpu_rd_q |-> ram_rdata == cpu_exp_q)
        else begin
            fail_count++;
            $error("ERROR %s: ram_rdata expected %h actual %h", test_name,
                   $sampled(cpu_exp_q), $sampled(ram_rdata));
        end

    a_isv_ptr: assert property (@(posedge sys) disable iff (!rst_n)
        isv_rd_ptr == ptr_sh)
        else begin
            fail_count++;
            $error("ERROR %s: isv_rd_ptr expected %h actual %h", test_name,
                   $sampled(ptr_sh), $sampled(isv_rd_ptr));
        end

endmodule

// ==== dv/cart_cfg_tb.sv ====
module cart_cfg_tb;

    import cart_pkg::*;
    import cfg_regs_pkg::*;

    localparam int ram_aw    = CPU_RAM_AW_DEFAULT;
    localparam int num_tests = 6;

    logic              sys;
    logic              rst_n;
    logic              host_request;
    logic              host_write;
    logic [15:0]       host_address;
    logic [15:0]       host_wdata;
    logic [15:0]       host_rdata;
    logic              host_ack;
    logic              soft_reset;
    logic              cpu_ready;
    logic              cmd_valid;
    logic [7:0]        cmd;
    logic [31:0]       cmd_arg0;
    logic [31:0]       cmd_arg1;
    logic              cmd_ready;
    logic              done;
    logic              done_error;
    logic [1:0]        data_write;
    logic [31:0]       result_data;
    logic [ram_aw-1:0] ram_address;
    logic              ram_write;
    logic [15:0]       ram_wdata;
    logic [15:0]       ram_rdata;
    logic [15:0]       isv_rd_ptr;

    logic [31:0] lfsr = 32'hec37_0c4e;
    string       cur_name;
    int          tb_errors = 0;
    int          fails_at_start;
    int          tests_run = 0;
    int          tests_failed = 0;

    cart_cfg_top #(.ram_aw(ram_aw)) u_cart_cfg_top (.*);

    bind cart_cfg_top cart_cfg_checker #(.ram_aw(ram_aw)) u_cart_cfg_checker (.*);

    initial begin
        sys = 1'b0;
        forever #50 sys = ~sys;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32 22 2 1.
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] cfg_addr(input cfg_reg_e r);
        return {REGION_CFG, 10'd0, r, 1'b0};
    endfunction

    function automatic logic [15:0] isv_addr(input isv_reg_e r);
        return {REGION_ISV, 9'd0, r, 1'b0};
    endfunction

    function automatic logic [15:0] ram_addr(input logic [12:0] idx);
        return {REGION_RAM, idx, 1'b0};
    endfunction

    task automatic host_access(input logic wr, input logic [15:0] addr, input logic [15:0] wd);
        int waited;
        @(posedge sys);
        host_request <= 1'b1;
        host_write   <= wr;
        host_address <= addr;
        host_wdata   <= wd;
        @(posedge sys);
        host_request <= 1'b0;
        waited = 0;
        do begin
            @(negedge sys);
            waited++;
        end while (!host_ack && waited < 4);
        if (!host_ack) begin
            $display("%s: host access to %h was never acknowledged", cur_name, addr);
            tb_errors++;
        end
        @(posedge sys);    // Wait cycle before the next request.
    endtask

    task automatic cpu_take_command(input logic [2:0] delay);
        int waited;
        waited = 0;
        do begin
            @(negedge sys);
            waited++;
        end while (!cmd_valid && waited < 8);
        if (!cmd_valid) begin
            $display("%s: cmd_valid never rose after a command write", cur_name);
            tb_errors++;
        end
        repeat (delay) @(posedge sys);
        @(posedge sys) cmd_ready <= 1'b1;
        @(posedge sys) cmd_ready <= 1'b0;
    endtask

    task automatic cpu_complete(input logic err, input logic [1:0] dw, input logic [31:0] res);
        @(posedge sys);
        done        <= 1'b1;
        done_error  <= err;
        data_write  <= dw;
        result_data <= res;
        @(posedge sys);
        done       <= 1'b0;
        data_write <= 2'b00;
    endtask

    task automatic start_test(input string name);
        cur_name = name;
        u_cart_cfg_top.u_cart_cfg_checker.test_name = name;
        fails_at_start = u_cart_cfg_top.u_cart_cfg_checker.fail_count + tb_errors;
    endtask

    task automatic finish_test;
        int n;
        repeat (2) @(posedge sys);    // Let pending checks fire.
        n = u_cart_cfg_top.u_cart_cfg_checker.fail_count + tb_errors - fails_at_start;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("test %-12s %s, %0d failures", cur_name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        #(num_tests * 200 * 100);
        $display("watchdog expired before all tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          total;
        rst_n        = 1'b0;
        host_request = 1'b0;
        host_write   = 1'b0;
        host_address = '0;
        host_wdata   = '0;
        soft_reset   = 1'b0;
        cpu_ready    = 1'b0;
        cmd_ready    = 1'b0;
        done         = 1'b0;
        done_error   = 1'b0;
        data_write   = 2'b00;
        result_data  = '0;
        ram_address  = '0;
        ram_write    = 1'b0;
        ram_wdata    = '0;
        repeat (5) @(posedge sys);
        rst_n     <= 1'b1;
        cpu_ready <= 1'b1;

        start_test("ack_timing");
        host_access(1'b0, cfg_addr(REG_VERSION_H), 16'd0);
        host_access(1'b0, cfg_addr(REG_VERSION_L), 16'd0);
        cpu_ready <= 1'b0;    // Ready bit low.
        host_access(1'b0, cfg_addr(REG_STATUS), 16'd0);
        cpu_ready <= 1'b1;
        host_access(1'b0, cfg_addr(REG_COMMAND), 16'd0);
        finish_test();

        start_test("data_words");
        for (int i = 2; i < 6; i++) begin
            take_bits(16, r);
            host_access(1'b1, cfg_addr(cfg_reg_e'(3'(i))), r[15:0]);
            host_access(1'b0, cfg_addr(cfg_reg_e'(3'(i))), 16'd0);
        end
        take_bits(14, r);
        host_access(1'b0, {REGION_NONE, r[13:0]}, 16'd0);
        finish_test();

        start_test("ram_window");
        for (int i = 0; i < 3; i++) begin
            take_bits(13, r);
            take_bits(16, r2);
            host_access(1'b1, ram_addr(r[12:0]), r2[15:0]);
            @(posedge sys) ram_address <= r[12:0];
            @(posedge sys);    // Registered read is compared here.
            take_bits(13, r);
            take_bits(16, r2);
            @(posedge sys);
            ram_address <= r[12:0];
            ram_write   <= 1'b1;
            ram_wdata   <= r2[15:0];
            @(posedge sys) ram_write <= 1'b0;
            host_access(1'b0, ram_addr(r[12:0]), 16'd0);
        end
        finish_test();

        start_test("cmd_handoff");
        for (int i = 0; i < 2; i++) begin
            take_bits(16, r);
            host_access(1'b1, cfg_addr(REG_DATA0_L), r[15:0]);
            take_bits(16, r);
            host_access(1'b1, cfg_addr(REG_DATA1_H), r[15:0]);
            take_bits(8, r);
            host_access(1'b1, cfg_addr(REG_COMMAND), r[15:0]);
            take_bits(3, r);
            cpu_take_command(r[2:0]);
            host_access(1'b0, cfg_addr(REG_STATUS), 16'd0);    // Busy.
            host_access(1'b0, cfg_addr(REG_COMMAND), 16'd0);
            cpu_complete(1'b0, 2'b00, 32'd0);
            host_access(1'b0, cfg_addr(REG_STATUS), 16'd0);
        end
        finish_test();

        start_test("completion");
        take_bits(8, r);
        host_access(1'b1, cfg_addr(REG_COMMAND), r[15:0]);
        cpu_take_command(3'd0);
        take_bits(32, r);
        cpu_complete(1'b0, 2'b11, r);
        for (int i = 2; i < 6; i++) begin
            host_access(1'b0, cfg_addr(cfg_reg_e'(3'(i))), 16'd0);
        end
        take_bits(8, r);
        host_access(1'b1, cfg_addr(REG_COMMAND), r[15:0]);
        cpu_take_command(3'd2);
        take_bits(8, r);
        host_access(1'b1, cfg_addr(REG_COMMAND), r[15:0]);    // Dropped while busy.
        host_access(1'b0, cfg_addr(REG_STATUS), 16'd0);
        cpu_complete(1'b0, 2'b00, 32'd0);
        host_access(1'b0, cfg_addr(REG_STATUS), 16'd0);
        take_bits(8, r);
        host_access(1'b1, cfg_addr(REG_COMMAND), r[15:0]);
        cpu_take_command(3'd1);
        take_bits(32, r);
        cpu_complete(1'b1, 2'b01, r);
        host_access(1'b0, cfg_addr(REG_STATUS), 16'd0);
        host_access(1'b0, cfg_addr(REG_DATA0_H), 16'd0);
        finish_test();

        start_test("isv");
        take_bits(16, r);
        host_access(1'b1, isv_addr(ISV_ID_H), r[15:0]);
        host_access(1'b0, isv_addr(ISV_ID_H), 16'd0);
        take_bits(16, r);
        host_access(1'b1, isv_addr(ISV_ID_L), r[15:0]);
        host_access(1'b0, isv_addr(ISV_ID_L), 16'd0);
        take_bits(16, r);
        host_access(1'b1, isv_addr(ISV_RD_PTR), r[15:0] | 16'h0001);
        host_access(1'b0, isv_addr(ISV_RD_PTR), 16'd0);
        @(posedge sys) soft_reset <= 1'b1;
        @(posedge sys) soft_reset <= 1'b0;
        host_access(1'b0, isv_addr(ISV_RD_PTR), 16'd0);
        finish_test();

        total = u_cart_cfg_top.u_cart_cfg_checker.fail_count + tb_errors;
        $display("tests run %0d, tests failed %0d, check failures %0d",
                 tests_run, tests_failed, total);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/cart_cfg_top.sv ====
module cart_cfg_top #(
    parameter int ram_aw = cart_pkg::CPU_RAM_AW_DEFAULT
) (
    input  logic              sys,
    input  logic              rst_n,
    input  logic              host_request,
    input  logic              host_write,
    input  logic [15:0]       host_address,
    input  logic [15:0]       host_wdata,
    output logic [15:0]       host_rdata,
    output logic              host_ack,
    input  logic              soft_reset,
    input  logic              cpu_ready,
    output logic              cmd_valid,
    output logic [7:0]        cmd,
    output logic [31:0]       cmd_arg0,
    output logic [31:0]       cmd_arg1,
    input  logic              cmd_ready,
    input  logic              done,
    input  logic              done_error,
    input  logic [1:0]        data_write,
    input  logic [31:0]       result_data,
    input  logic [ram_aw-1:0] ram_address,
    input  logic              ram_write,
    input  logic [15:0]       ram_wdata,
    output logic [15:0]       ram_rdata,
    output logic [15:0]       isv_rd_ptr
);

    import cfg_regs_pkg::*;

    logic [ram_aw-1:0] ram_host_address;
    logic              ram_host_write;
    logic [15:0]       ram_host_wdata;
    logic [15:0]       ram_host_rdata;
    logic              cmd_start;
    logic [7:0]        cmd_byte;
    data_word_u        data0;
    data_word_u        data1;
    logic [1:0]        load_data;
    logic [31:0]       load_value;
    logic              cpu_busy;
    logic              cmd_error;

    host_cfg #(
        .ram_aw (ram_aw)
    ) u_host_cfg (
        .sys, .rst_n,
        .host_request, .host_write, .host_address, .host_wdata, .host_rdata, .host_ack,
        .soft_reset,
        .ram_host_address, .ram_host_write, .ram_host_wdata, .ram_host_rdata,
        .cmd_start, .cmd (cmd_byte), .data0, .data1, .load_data, .load_value,
        .cpu_ready, .cpu_busy, .cmd_error, .isv_rd_ptr
    );

    cpu_cmd_port u_cpu_cmd_port (
        .sys, .rst_n,
        .cmd_start, .cmd_in (cmd_byte), .data0, .data1,
        .cmd_valid, .cmd, .cmd_arg0, .cmd_arg1,
        .cmd_ready, .done, .done_error, .data_write, .result_data,
        .load_data, .load_value, .cpu_busy, .cmd_error
    );

    // Port a is the host window, port b the local CPU.
    cpu_ram #(
        .ram_aw (ram_aw)
    ) u_cpu_ram (
        .sys,
        .a_address (ram_host_address), .a_write (ram_host_write),
        .a_wdata   (ram_host_wdata),   .a_rdata (ram_host_rdata),
        .b_address (ram_address),      .b_write (ram_write),
        .b_wdata   (ram_wdata),        .b_rdata (ram_rdata)
    );

endmodule

// ==== rtl/cart_pkg.sv ====
package cart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Firmware identification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [31:0] cart_version = 32'h0002_0104;    // Major, minor, patch.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host address map, bits 15:14
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [1:0] REGION_CFG  = 2'b00;    // Status, command, data, version.
    localparam logic [1:0] REGION_RAM  = 2'b01;    // Byte-swapped CPU RAM window.
    localparam logic [1:0] REGION_NONE = 2'b10;    // Reads as zero.
    localparam logic [1:0] REGION_ISV  = 2'b11;    // Viewer id and read pointer.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared CPU RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 8K halfwords, host byte address bits 13:1.
    localparam int CPU_RAM_AW_DEFAULT = 13;

endpackage

// ==== rtl/cfg_regs_pkg.sv ====
package cfg_regs_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Region 0, halfword index from address bits 3:1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        REG_STATUS,
        REG_COMMAND,
        REG_DATA0_H,
        REG_DATA0_L,
        REG_DATA1_H,
        REG_DATA1_L,
        REG_VERSION_H,
        REG_VERSION_L
    } cfg_reg_e;

    // Region 3, halfword index from address bits 4:1.
    typedef enum logic [3:0] {
        ISV_ID_H   = 4'h0,
        ISV_ID_L   = 4'h1,
        ISV_RD_PTR = 4'hb
    } isv_reg_e;

    // Data word as seen by both sides of the mailbox.
    typedef union packed {
        logic [31:0]      word;    // CPU view.
        logic [1:0][15:0] half;    // Host view. Index 1 holds the high half.
    } data_word_u;

endpackage

// ==== rtl/cpu_cmd_port.sv ====
module cpu_cmd_port (
    input  logic                     sys,
    input  logic                     rst_n,
    input  logic                     cmd_start,
    input  logic [7:0]               cmd_in,
    input  cfg_regs_pkg::data_word_u data0,
    input  cfg_regs_pkg::data_word_u data1,
    output logic                     cmd_valid,
    output logic [7:0]               cmd,
    output logic [31:0]              cmd_arg0,
    output logic [31:0]              cmd_arg1,
    input  logic                     cmd_ready,
    input  logic                     done,
    input  logic                     done_error,
    input  logic [1:0]               data_write,
    input  logic [31:0]              result_data,
    output logic [1:0]               load_data,
    output logic [31:0]              load_value,
    output logic                     cpu_busy,
    output logic                     cmd_error
);

    logic accept;

    assign accept = cmd_start && !cpu_busy;    // Dropped while busy.

    // Completion forwarding, loaded by host_cfg on this edge.
    assign load_data  = done ? data_write : 2'b00;
    assign load_value = result_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys) begin
        if (accept) begin
            cmd      <= cmd_in;
            cmd_arg0 <= data0.word;
            cmd_arg1 <= data1.word;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hand-off and busy tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
            cpu_busy  <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) cmd_valid <= 1'b0;    // Taken by CPU.

            if (done) begin
                cpu_busy  <= 1'b0;
                cmd_error <= done_error;
            end

            if (accept) begin
                cmd_valid <= 1'b1;
                cpu_busy  <= 1'b1;
            end else if (cmd_start) begin
                cmd_error <= 1'b1;    // Overlapping command.
            end
        end
    end

endmodule

// ==== rtl/cpu_ram.sv ====
module cpu_ram #(
    parameter int ram_aw = cart_pkg::CPU_RAM_AW_DEFAULT
) (
    input  logic              sys,
    input  logic [ram_aw-1:0] a_address,
    input  logic              a_write,
    input  logic [15:0]       a_wdata,
    output logic [15:0]       a_rdata,
    input  logic [ram_aw-1:0] b_address,
    input  logic              b_write,
    input  logic [15:0]       b_wdata,
    output logic [15:0]       b_rdata
);

    logic [15:0] mem [2**ram_aw];

    // Both ports in one process. Same-address writes collide.
    always_ff @(posedge sys) begin
        if (a_write) begin
            mem[a_address] <= a_wdata;
        end
        if (b_write) begin
            mem[b_address] <= b_wdata;
        end
    end

    // Registered reads return the old word on a write.
    always_ff @(posedge sys) begin
        a_rdata <= mem[a_address];
        b_rdata <= mem[b_address];
    end

endmodule

// ==== rtl/host_cfg.sv ====
module host_cfg #(
    parameter int ram_aw = cart_pkg::CPU_RAM_AW_DEFAULT
) (
    input  logic                     sys,
    input  logic                     rst_n,
    input  logic                     host_request,
    input  logic                     host_write,
    input  logic [15:0]              host_address,
    input  logic [15:0]              host_wdata,
    output logic [15:0]              host_rdata,
    output logic                     host_ack,
    input  logic                     soft_reset,
    output logic [ram_aw-1:0]        ram_host_address,
    output logic                     ram_host_write,
    output logic [15:0]              ram_host_wdata,
    input  logic [15:0]              ram_host_rdata,
    output logic                     cmd_start,
    output logic [7:0]               cmd,
    output cfg_regs_pkg::data_word_u data0,
    output cfg_regs_pkg::data_word_u data1,
    input  logic [1:0]               load_data,
    input  logic [31:0]              load_value,
    input  logic                     cpu_ready,
    input  logic                     cpu_busy,
    input  logic                     cmd_error,
    output logic [15:0]              isv_rd_ptr
);

    import cart_pkg::*;
    import cfg_regs_pkg::*;

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic        state;
    logic        accept;
    logic [1:0]  region;
    logic [31:0] isv_id;

    assign region = host_address[15:14];
    assign accept = host_request && (state == ST_IDLE);    // Ignored in the ack cycle.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAM window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ram_host_address = host_address[ram_aw:1];
    assign ram_host_write   = accept && host_write && (region == REGION_RAM);
    assign ram_host_wdata   = {host_wdata[7:0], host_wdata[15:8]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux, valid only during ack
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        host_rdata = 16'd0;
        if (host_ack) begin
            case (region)
                REGION_CFG: begin
                    case (cfg_reg_e'(host_address[3:1]))
                        REG_STATUS: begin
                            host_rdata = {cpu_ready, cpu_busy, 1'b0, cmd_error, 12'd0};
                        end
                        REG_COMMAND:   host_rdata = {8'd0, cmd};
                        REG_DATA0_H:   host_rdata = data0.half[1];
                        REG_DATA0_L:   host_rdata = data0.half[0];
                        REG_DATA1_H:   host_rdata = data1.half[1];
                        REG_DATA1_L:   host_rdata = data1.half[0];
                        REG_VERSION_H: host_rdata = cart_version[31:16];
                        REG_VERSION_L: host_rdata = cart_version[15:0];
                    endcase
                end
                REGION_RAM: host_rdata = {ram_host_rdata[7:0], ram_host_rdata[15:8]};
                REGION_ISV: begin
                    case (isv_reg_e'(host_address[4:1]))
                        ISV_ID_H:   host_rdata = isv_id[31:16];
                        ISV_ID_L:   host_rdata = isv_id[15:0];
                        ISV_RD_PTR: host_rdata = isv_rd_ptr;
                        default:    host_rdata = 16'd0;
                    endcase
                end
                default: host_rdata = 16'd0;    // REGION_NONE.
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ack sequencer and register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            host_ack   <= 1'b0;
            cmd_start  <= 1'b0;
            cmd        <= 8'd0;
            data0      <= '0;
            data1      <= '0;
            isv_id     <= 32'd0;
            isv_rd_ptr <= 16'd0;
        end else begin
            host_ack  <= 1'b0;
            cmd_start <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (host_request) begin
                        state    <= ST_WAIT;
                        host_ack <= 1'b1;
                    end
                end
                ST_WAIT: state <= ST_IDLE;
            endcase

            if (accept && host_write) begin
                if (region == REGION_CFG) begin
                    case (cfg_reg_e'(host_address[3:1]))
                        REG_COMMAND: begin
                            cmd       <= host_wdata[7:0];
                            cmd_start <= 1'b1;
                        end
                        REG_DATA0_H: data0.half[1] <= host_wdata;
                        REG_DATA0_L: data0.half[0] <= host_wdata;
                        REG_DATA1_H: data1.half[1] <= host_wdata;
                        REG_DATA1_L: data1.half[0] <= host_wdata;
                        default: ;    // Status and version are read only.
                    endcase
                end else if (region == REGION_ISV) begin
                    case (isv_reg_e'(host_address[4:1]))
                        ISV_ID_H:   isv_id[31:16] <= host_wdata;
                        ISV_ID_L:   isv_id[15:0]  <= host_wdata;
                        ISV_RD_PTR: isv_rd_ptr    <= host_wdata;
                        default: ;
                    endcase
                end
            end

            // Completion loads win over host writes.
            if (load_data[0]) data0.word <= load_value;
            if (load_data[1]) data1.word <= load_value;

            if (soft_reset) isv_rd_ptr <= 16'd0;
        end
    end

endmodule

// ==== vlog.f ====
rtl/cart_pkg.sv
rtl/cfg_regs_pkg.sv
rtl/cpu_ram.sv
rtl/cpu_cmd_port.sv
rtl/host_cfg.sv
rtl/cart_cfg_top.sv
dv/cart_cfg_checker.sv
dv/cart_cfg_tb.sv
